// File: vlog.f
+incdir+verif
common/alu_pkg.sv
alu_rs/alu_rs.sv
src/alu_exec.sv
src/alu_cluster.sv
verif/alu_cluster_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and decides on the printed pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module alu_cluster_tb -o sim_alu_cluster \
  || { echo "build failed"; exit 1; }

out=$(./obj_dir/sim_alu_cluster 2>&1)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "ALL TESTS PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: verif/alu_model.svh
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// reference state, indexed by tag, tag zero is never handed out
logic [31:0] rng_state;
bit          tag_busy    [16];
bit          alu_pending [16];  // ALU instruction dispatched, result not seen yet
bit          ext_pending [16];  // external tag still waiting for its broadcast
int          ext_delay   [16];
logic [31:0] tag_value   [16];  // value that each tag will carry on its bus
int          live_bcast;        // external tag on ext_bcast during this cycle
int          retiring;          // ALU tag on result during this cycle
int          dispatched;
int          seen;

function automatic logic [31:0] xorshift();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

// operation table written out independently of the RTL
function automatic logic [31:0] ref_op(alu_op_e op, logic [31:0] a, logic [31:0] b);
  logic [4:0]  s;
  logic [31:0] fill;
  s    = b[4:0];
  fill = a[31] ? ~(32'hffff_ffff >> s) : 32'h0;
  case (op)
    ADD:     return a + b;
    SUB:     return a + ~b + 32'd1;
    AND:     return a & b;
    OR:      return a | b;
    NOR:     return ~a & ~b;
    XOR:     return (a | b) & ~(a & b);
    SLL:     return a << s;
    SRL:     return a >> s;
    SRA:     return (a >> s) | fill;
    ROR:     return (s == 5'd0) ? a : ((a >> s) | (a << (6'd32 - {1'b0, s})));
    SEQ:     return {31'b0, a == b};
    SLT:     return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
    SLTU:    return {31'b0, a < b};
    default: return 32'h0;
  endcase
endfunction

// edge values turn up about a quarter of the time
function automatic logic [31:0] rand_value();
  logic [31:0] r;
  r = xorshift();
  if (r[1:0] != 2'd0) return xorshift();
  case (r[4:2])
    3'd0:    return 32'h0;
    3'd1:    return 32'hffff_ffff;
    3'd2:    return 32'h8000_0000;
    3'd3:    return 32'd31;
    3'd4:    return 32'h7fff_ffff;
    default: return 32'd1;
  endcase
endfunction

function automatic int free_tag_count();
  int n;
  n = 0;
  for (int t = 1; t < 16; t++) if (!tag_busy[t]) n++;
  return n;
endfunction

function automatic int alloc_tag();
  int start;
  int t;
  start = int'(xorshift() % 32'd15);
  for (int k = 0; k < 15; k++) begin
    t = 1 + (start + k) % 15;
    if (!tag_busy[t]) begin
      tag_busy[t] = 1'b1;
      return t;
    end
  end
  return 0;
endfunction

function automatic int count_alu_pending();
  int n;
  n = 0;
  for (int t = 1; t < 16; t++) if (alu_pending[t]) n++;
  return n;
endfunction

function automatic int count_ext_pending();
  int n;
  n = 0;
  for (int t = 1; t < 16; t++) if (ext_pending[t]) n++;
  return n;
endfunction

// random pick among flagged tags, zero when none is flagged
function automatic int pick_tag(bit use_ext);
  int start;
  int t;
  start = int'(xorshift() % 32'd15);
  for (int k = 0; k < 15; k++) begin
    t = 1 + (start + k) % 15;
    if (use_ext ? ext_pending[t] : alu_pending[t]) return t;
  end
  return 0;
endfunction

`endif

// File: verif/alu_cluster_tb.sv
`timescale 1ns/1ps

module alu_cluster_tb
  import alu_pkg::*;
;

  localparam int RS_DEPTH       = 4;
  localparam int RESET_CYCLES   = 4;
  localparam int N_RANDOM       = 300;
  localparam int N_EDGE         = 5;
  localparam int N_DIRECTED     = 13 * N_EDGE + RS_DEPTH + 1;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 20 * (N_RANDOM + N_DIRECTED);
  localparam int DRAIN_CYCLES   = 20 * RS_DEPTH;
  localparam int HOLD_DELAY     = 1 << 30;

  logic      clk;
  logic      rst;
  dispatch_t dispatch;
  cdb_t      ext_bcast;
  logic      full;
  cdb_t      result;

  `include "alu_model.svh"

  alu_cluster #(
    .RS_DEPTH (RS_DEPTH)
  ) u_dut (
    .clk       (clk),
    .rst       (rst),
    .dispatch  (dispatch),
    .ext_bcast (ext_bcast),
    .full      (full),
    .result    (result)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopping at first error");
    end
  endtask

  // result is stable at the falling edge, halfway through its cycle
  task automatic observe();
    int t;
    if (result.valid === 1'b1) begin
      t = int'(result.tag);
      check("result.tag in flight", {31'b0, alu_pending[t]}, 32'd1);
      check("result.value", result.value, tag_value[t]);
      alu_pending[t] = 1'b0;
      retiring       = t;  // the tag stays on the forwarding lane until the next edge
      seen++;
    end else begin
      check("result.valid", {31'b0, result.valid}, 32'd0);
    end
  endtask

  // at most one external broadcast per cycle
  task automatic bcast_step();
    ext_bcast = '0;
    for (int t = 1; t < 16; t++) begin
      if (ext_pending[t] && ext_delay[t] > 0) ext_delay[t]--;
    end
    for (int t = 1; t < 16; t++) begin
      if (ext_pending[t] && ext_delay[t] == 0 && live_bcast == 0) begin
        ext_bcast.valid = 1'b1;
        ext_bcast.tag   = 4'(t);
        ext_bcast.value = tag_value[t];
        ext_delay[t]    = -1;
        live_bcast      = t;
      end
    end
  endtask

  task automatic tick();
    @(negedge clk);
    dispatch = '0;
    if (live_bcast != 0) begin
      ext_pending[live_bcast] = 1'b0;  // its broadcast cycle is over
      tag_busy[live_bcast]    = 1'b0;
      live_bcast              = 0;
    end
    if (retiring != 0) begin
      tag_busy[retiring] = 1'b0;
      retiring           = 0;
    end
    observe();
    bcast_step();
  endtask

  task automatic wait_slot(input int need);
    while (full !== 1'b0 || free_tag_count() < need) tick();
  endtask

  function automatic operand_t ready_operand(input logic [31:0] v);
    operand_t o;
    o.tag   = TAG_NONE;
    o.value = v;
    return o;
  endfunction

  function automatic logic [31:0] operand_value(input operand_t o);
    return (o.tag == TAG_NONE) ? o.value : tag_value[o.tag];
  endfunction

  task automatic send(input alu_op_e op, input operand_t s1, input operand_t s2);
    int dst;
    dst = alloc_tag();
    tag_value[dst]   = ref_op(op, operand_value(s1), operand_value(s2));
    alu_pending[dst] = 1'b1;
    dispatch.valid   = 1'b1;
    dispatch.dst     = 4'(dst);
    dispatch.op      = op;
    dispatch.src1    = s1;
    dispatch.src2    = s2;
    dispatched++;
  endtask

  task automatic make_operand(output operand_t o);
    logic [31:0] r;
    int          t;
    r = xorshift();
    t = 0;
    if (r[1:0] == 2'd1) begin
      t = pick_tag(1'b0);  // forwarded from an earlier ALU instruction
    end else if (r[1:0] == 2'd2) begin
      if (r[2] && count_ext_pending() < 4) begin
        t = alloc_tag();
        tag_value[t]   = rand_value();
        ext_pending[t] = 1'b1;
        ext_delay[t]   = int'(xorshift() % 32'd12);
      end else if (r[3] && live_bcast != 0) begin
        t = live_bcast;  // broadcast lands in the dispatch cycle
      end else begin
        t = pick_tag(1'b1);
      end
    end
    o.tag   = 4'(t);
    o.value = (t == 0) ? rand_value() : xorshift();
  endtask

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: results were still missing when the watchdog ran out");
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [31:0] a_edge [N_EDGE];
    logic [31:0] b_edge [N_EDGE];
    operand_t    s1;
    operand_t    s2;
    int          hold;
    int          drain;

    a_edge = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff, 32'h1234_5678};
    b_edge = '{32'h0, 32'd1, 32'd31, 32'hffff_ffff, 32'h8000_0000};
    rng_state  = 32'd57;
    live_bcast = 0;
    retiring   = 0;
    dispatched = 0;
    seen       = 0;
    for (int t = 0; t < 16; t++) begin
      tag_busy[t]    = 1'b0;
      alu_pending[t] = 1'b0;
      ext_pending[t] = 1'b0;
      ext_delay[t]   = 0;
      tag_value[t]   = 32'h0;
    end
    rst       = 1'b1;
    dispatch  = '0;
    ext_bcast = '0;

    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      @(negedge clk);
      check("result.valid", {31'b0, result.valid}, 32'd0);
      check("full", {31'b0, full}, 32'd0);
    end
    rst = 1'b0;
    tick();
    check("full", {31'b0, full}, 32'd0);

    // every opcode with ready edge operands
    for (int op = 0; op < 13; op++) begin
      for (int e = 0; e < N_EDGE; e++) begin
        tick();
        wait_slot(1);
        send(alu_op_e'(4'(op)), ready_operand(a_edge[e]), ready_operand(b_edge[e]));
      end
    end

    // fill the station behind a tag that is held back
    while (count_alu_pending() != 0 || count_ext_pending() != 0) tick();
    check("full", {31'b0, full}, 32'd0);
    hold = alloc_tag();
    tag_value[hold]   = rand_value();
    ext_pending[hold] = 1'b1;
    ext_delay[hold]   = HOLD_DELAY;
    for (int i = 1; i <= RS_DEPTH; i++) begin
      s1.tag   = 4'(hold);
      s1.value = xorshift();
      send(alu_op_e'(4'(i)), s1, ready_operand(rand_value()));
      tick();
      check("full", {31'b0, full}, {31'b0, i == RS_DEPTH});
    end
    tick();
    check("full", {31'b0, full}, 32'd1);
    ext_delay[hold] = 0;
    tick();  // hold is on ext_bcast now
    tick();
    check("full", {31'b0, full}, 32'd1);
    tick();
    check("full", {31'b0, full}, 32'd0);
    send(XOR, ready_operand(rand_value()), ready_operand(rand_value()));

    for (int n = 0; n < N_RANDOM; n++) begin
      tick();
      wait_slot(3);
      make_operand(s1);
      make_operand(s2);
      send(alu_op_e'(4'(xorshift() % 32'd13)), s1, s2);
    end

    // every outstanding result must show up within a bounded drain
    drain = 0;
    while ((count_alu_pending() != 0 || count_ext_pending() != 0) && drain < DRAIN_CYCLES) begin
      tick();
      drain++;
    end
    repeat (3) tick();
    check("tags seen on result", 32'(seen), 32'(dispatched));
    check("scoreboard entries left", 32'(count_alu_pending()), 32'd0);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: src/alu_cluster.sv
`timescale 1ns/1ps

module alu_cluster
  import alu_pkg::*;
#(
  parameter int RS_DEPTH = 4
) (
  input  logic      clk,
  input  logic      rst,
  input  dispatch_t dispatch,
  input  cdb_t      ext_bcast,
  output logic      full,
  output cdb_t      result
);

  issue_t issue;

  // the station sees the ALU result as its second wakeup lane
  alu_rs #(
    .RS_DEPTH (RS_DEPTH)
  ) u_rs (
    .clk       (clk),
    .rst       (rst),
    .dispatch  (dispatch),
    .ext_bcast (ext_bcast),
    .fwd_bcast (result),
    .full      (full),
    .issue     (issue)
  );

  alu_exec u_exec (
    .clk    (clk),
    .rst    (rst),
    .issue  (issue),
    .result (result)
  );

endmodule

// File: src/alu_exec.sv
`timescale 1ns/1ps

module alu_exec
  import alu_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  issue_t issue,
  output cdb_t   result
);

  logic [XLEN-1:0]  alu_out;
  logic             valid_q;
  logic [TAG_W-1:0] tag_q;
  logic [XLEN-1:0]  value_q;

  assign alu_out = alu_compute(issue.op, issue.val1, issue.val2);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue.valid;
    end
  end

  // payload only loads on an issue, the bus keeps its last value otherwise
  always_ff @(posedge clk) begin
    if (issue.valid) begin
      tag_q   <= issue.dst;
      value_q <= alu_out;
    end
  end

  assign result.valid = valid_q;
  assign result.tag   = tag_q;
  assign result.value = value_q;

endmodule

// File: alu_rs/alu_rs.sv
`timescale 1ns/1ps

module alu_rs
  import alu_pkg::*;
#(
  parameter int RS_DEPTH = 4
) (
  input  logic      clk,
  input  logic      rst,
  input  dispatch_t dispatch,
  input  cdb_t      ext_bcast,
  input  cdb_t      fwd_bcast,
  output logic      full,
  output issue_t    issue
);

  localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

  // payload of one station slot, the valid bit is kept apart
  typedef struct packed {
    logic [TAG_W-1:0] dst;
    alu_op_e          op;
    operand_t         src1;
    operand_t         src2;
  } rs_entry_t;

  logic [RS_DEPTH-1:0] valid_q;
  logic [RS_DEPTH-1:0] valid_d;
  rs_entry_t           entry_q [RS_DEPTH];
  rs_entry_t           entry_d [RS_DEPTH];

  logic [RS_DEPTH-1:0] ready;
  logic                free_found;
  logic [IDX_W-1:0]    free_idx;
  logic                sel_found;
  logic [IDX_W-1:0]    sel_idx;

  operand_t            disp_src1;
  operand_t            disp_src2;

  // a lane matches only a waiting operand, so a ready one is never overwritten
  function automatic logic lane_hit(cdb_t lane, logic [TAG_W-1:0] tag);
    return lane.valid && (tag != TAG_NONE) && (lane.tag == tag);
  endfunction

  function automatic operand_t wake(operand_t opnd, cdb_t lane_a, cdb_t lane_b);
    operand_t res;
    res = opnd;
    if (lane_hit(lane_a, opnd.tag)) begin
      res.tag   = TAG_NONE;
      res.value = lane_a.value;
    end else if (lane_hit(lane_b, opnd.tag)) begin
      res.tag   = TAG_NONE;
      res.value = lane_b.value;
    end
    return res;
  endfunction

  always_comb begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      ready[i] = valid_q[i] &&
                 (entry_q[i].src1.tag == TAG_NONE) &&
                 (entry_q[i].src2.tag == TAG_NONE);
    end
  end

  // later iterations overwrite earlier ones, so the highest free index wins
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (!valid_q[i]) begin
        free_found = 1'b1;
        free_idx   = IDX_W'(i);
      end
    end
  end

  always_comb begin
    sel_found = 1'b0;
    sel_idx   = '0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (ready[i]) begin
        sel_found = 1'b1;
        sel_idx   = IDX_W'(i);  // highest ready entry goes first
      end
    end
  end

  assign full = &valid_q;

  // a broadcast in the dispatch cycle is caught on the way into the slot
  assign disp_src1 = wake(dispatch.src1, ext_bcast, fwd_bcast);
  assign disp_src2 = wake(dispatch.src2, ext_bcast, fwd_bcast);

  always_comb begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      valid_d[i]      = valid_q[i];
      entry_d[i]      = entry_q[i];
      entry_d[i].src1 = wake(entry_q[i].src1, ext_bcast, fwd_bcast);
      entry_d[i].src2 = wake(entry_q[i].src2, ext_bcast, fwd_bcast);

      if (sel_found && (sel_idx == IDX_W'(i))) begin
        valid_d[i] = 1'b0;  // issued this cycle
      end

      // the free slot is picked from current valid bits, so it never clashes with issue
      if (dispatch.valid && free_found && (free_idx == IDX_W'(i))) begin
        valid_d[i]      = 1'b1;
        entry_d[i].dst  = dispatch.dst;
        entry_d[i].op   = dispatch.op;
        entry_d[i].src1 = disp_src1;
        entry_d[i].src2 = disp_src2;
      end
    end
  end

  always_comb begin
    issue = '0;
    if (sel_found) begin
      issue.valid = 1'b1;
      issue.dst   = entry_q[sel_idx].dst;
      issue.op    = entry_q[sel_idx].op;
      issue.val1  = entry_q[sel_idx].src1.value;
      issue.val2  = entry_q[sel_idx].src2.value;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      entry_q[i] <= entry_d[i];
    end
  end

endmodule

// File: common/alu_pkg.sv
package alu_pkg;

  localparam int XLEN  = 32;
  localparam int TAG_W = 4;

  // tag zero means no producer in an operand and no instruction elsewhere
  localparam logic [TAG_W-1:0] TAG_NONE = '0;

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    NOR  = 4'd4,
    XOR  = 4'd5,
    SLL  = 4'd6,
    SRL  = 4'd7,
    SRA  = 4'd8,
    ROR  = 4'd9,
    SEQ  = 4'd10,
    SLT  = 4'd11,
    SLTU = 4'd12
  } alu_op_e;

  // ready once tag is TAG_NONE, value is only meaningful then
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  value;
  } operand_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] dst;
    alu_op_e          op;
    operand_t         src1;
    operand_t         src2;
  } dispatch_t;

  // shared by the external bus, the forwarding lane and the result output
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  value;
  } cdb_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] dst;
    alu_op_e          op;
    logic [XLEN-1:0]  val1;
    logic [XLEN-1:0]  val2;
  } issue_t;

  function automatic logic [XLEN-1:0] alu_compute(alu_op_e op, logic [XLEN-1:0] a,
                                                   logic [XLEN-1:0] b);
    logic [4:0]        sh;
    logic [2*XLEN-1:0] rot;
    logic [XLEN-1:0]   res;
    sh  = b[4:0];  // every shift and rotate takes its amount from operand 2
    rot = {a, a} >> sh;
    case (op)
      ADD:     res = a + b;
      SUB:     res = a - b;
      AND:     res = a & b;
      OR:      res = a | b;
      NOR:     res = ~(a | b);
      XOR:     res = a ^ b;
      SLL:     res = a << sh;
      SRL:     res = a >> sh;
      SRA:     res = $unsigned($signed(a) >>> sh);
      ROR:     res = rot[XLEN-1:0];  // low half of the doubled word is the rotate
      SEQ:     res = (a == b) ? XLEN'(1) : '0;
      SLT:     res = ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
      SLTU:    res = (a < b) ? XLEN'(1) : '0;
      default: res = '0;
    endcase
    return res;
  endfunction

endpackage
